/* hdl/cache_pkg.sv */
package cache_pkg;

  // One data word as seen on the APB port and in main memory
  typedef logic [15:0] data_t;

  // Word address covering the whole backing memory
  typedef logic [11:0] word_addr_t;

  // Word position inside a 4-word line
  typedef logic [1:0] offset_t;

  // Controller states
  // Three of the eight encodings are unused and lead to ST_ERROR
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_WRITE_BACK = 3'd1,
    ST_FILL       = 3'd2,
    ST_COMPARE    = 3'd3,
    ST_ERROR      = 3'd4
  } ctrl_state_t;

endpackage

/* hdl/beat_counter.sv */
module beat_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                step,
  output cache_pkg::offset_t  beat,
  output logic                last_beat
);

  // Start wins over step so a new transfer always begins at word 0
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      beat <= '0;
    else if (start)
      beat <= '0;
    else if (step)
      beat <= beat + 1'b1;
  end

  // Beat 3 closes the line transfer
  assign last_beat = &beat;

endmodule

/* hdl/cache_array.sv */
module cache_array #(
  parameter int INDEX_BITS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::word_addr_t cpu_addr,
  input  cache_pkg::data_t      cpu_wdata,
  input  cache_pkg::offset_t    beat,
  input  logic                  fill_wr,
  input  logic                  cpu_wr,
  input  logic                  addr_sel,
  input  cache_pkg::data_t      fill_data,
  output logic                  hit,
  output logic                  dirty,
  output cache_pkg::data_t      cpu_rdata,
  output cache_pkg::data_t      line_rdata,
  output cache_pkg::word_addr_t mem_addr
);

  localparam int ADDR_BITS = $bits(cache_pkg::word_addr_t);
  localparam int OFF_BITS  = $bits(cache_pkg::offset_t);
  localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - OFF_BITS;
  localparam int LINES     = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0]   tag_q [LINES];
  logic [LINES-1:0]      valid_q;
  logic [LINES-1:0]      dirty_q;
  cache_pkg::data_t      data_q [LINES << OFF_BITS];

  logic [TAG_BITS-1:0]   cpu_tag;
  logic [INDEX_BITS-1:0] cpu_index;
  cache_pkg::offset_t    cpu_offset;
  logic                  fill_last;

  // Address split into tag, index and word offset
  assign cpu_tag    = cpu_addr[ADDR_BITS-1 -: TAG_BITS];
  assign cpu_index  = cpu_addr[OFF_BITS +: INDEX_BITS];
  assign cpu_offset = cpu_addr[OFF_BITS-1:0];

  assign fill_last = fill_wr && (&beat);

  // Lookup for the indexed line
  assign hit   = valid_q[cpu_index] && (tag_q[cpu_index] == cpu_tag);
  assign dirty = valid_q[cpu_index] && dirty_q[cpu_index];

  assign cpu_rdata  = data_q[{cpu_index, cpu_offset}];
  assign line_rdata = data_q[{cpu_index, beat}];

  // Victim address during write-back, requested line during fill
  assign mem_addr = addr_sel ? {tag_q[cpu_index], cpu_index, beat}
                             : {cpu_tag, cpu_index, beat};

  always_ff @(posedge clk)
  begin
    if (fill_wr)
      data_q[{cpu_index, beat}] <= fill_data;
    else if (cpu_wr)
      data_q[{cpu_index, cpu_offset}] <= cpu_wdata;
  end

  // Tag changes only once the whole line is in
  always_ff @(posedge clk)
  begin
    if (fill_last)
      tag_q[cpu_index] <= cpu_tag;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (fill_last)
    begin
      valid_q[cpu_index] <= 1'b1;
      dirty_q[cpu_index] <= 1'b0;
    end
    else if (cpu_wr)
      dirty_q[cpu_index] <= 1'b1;
  end

endmodule

/* hdl/main_memory.sv */
module main_memory (
  input  logic                  clk,
  input  logic                  wr,
  input  cache_pkg::word_addr_t addr,
  input  cache_pkg::data_t      wdata,
  output cache_pkg::data_t      rdata
);

  localparam int DEPTH = 1 << $bits(cache_pkg::word_addr_t);

  cache_pkg::data_t mem [DEPTH];

  // Known contents for addresses never written
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[addr] <= wdata;
  end

  // One word per cycle, no latency
  assign rdata = mem[addr];

endmodule

/* hdl/cache_fsm.sv */
module cache_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic                    hit,
  input  logic                    dirty,
  input  logic                    last_beat,
  output logic                    pready,
  output logic                    beat_start,
  output logic                    beat_step,
  output logic                    fill_wr,
  output logic                    cpu_wr,
  output logic                    mem_wr,
  output logic                    addr_sel,
  output cache_pkg::ctrl_state_t  state
);

  cache_pkg::ctrl_state_t state_d;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= cache_pkg::ST_IDLE;
    else
      state <= state_d;
  end

  always_comb
  begin
    // Everything inactive unless a state asks for it
    state_d    = state;
    pready     = 1'b0;
    beat_start = 1'b0;
    beat_step  = 1'b0;
    fill_wr    = 1'b0;
    cpu_wr     = 1'b0;
    mem_wr     = 1'b0;
    addr_sel   = 1'b0;

    case (state)
      cache_pkg::ST_IDLE:
      begin
        // Only the access phase is acted on, setup is ignored
        if (psel && penable)
        begin
          if (hit)
          begin
            pready = 1'b1;
            cpu_wr = pwrite;
          end
          else
          begin
            beat_start = 1'b1;
            if (dirty)
              state_d = cache_pkg::ST_WRITE_BACK;
            else
              state_d = cache_pkg::ST_FILL;
          end
        end
      end

      cache_pkg::ST_WRITE_BACK:
      begin
        // Victim line goes out one word per cycle
        mem_wr    = 1'b1;
        addr_sel  = 1'b1;
        beat_step = 1'b1;
        if (last_beat)
        begin
          beat_start = 1'b1;
          state_d    = cache_pkg::ST_FILL;
        end
      end

      cache_pkg::ST_FILL:
      begin
        fill_wr   = 1'b1;
        beat_step = 1'b1;
        if (last_beat)
          state_d = cache_pkg::ST_COMPARE;
      end

      cache_pkg::ST_COMPARE:
      begin
        // Line is resident now, so the access finishes here
        pready  = 1'b1;
        cpu_wr  = pwrite;
        state_d = cache_pkg::ST_IDLE;
      end

      cache_pkg::ST_ERROR:
        state_d = cache_pkg::ST_ERROR;

      default:
        state_d = cache_pkg::ST_ERROR;
    endcase
  end

endmodule

/* hdl/cache_top.sv */
module cache_top #(
  parameter int INDEX_BITS = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  cache_pkg::word_addr_t paddr,
  input  cache_pkg::data_t      pwdata,
  output cache_pkg::data_t      prdata,
  output logic                  pready
);

  // Controller to datapath
  logic                   beat_start;
  logic                   beat_step;
  logic                   fill_wr;
  logic                   cpu_wr;
  logic                   mem_wr;
  logic                   addr_sel;

  // Datapath back to controller
  logic                   hit;
  logic                   dirty;
  logic                   last_beat;
  cache_pkg::offset_t     beat;

  // Memory side
  cache_pkg::word_addr_t  mem_addr;
  cache_pkg::data_t       line_rdata;
  cache_pkg::data_t       mem_rdata;

  cache_fsm cache_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .hit        (hit),
    .dirty      (dirty),
    .last_beat  (last_beat),
    .pready     (pready),
    .beat_start (beat_start),
    .beat_step  (beat_step),
    .fill_wr    (fill_wr),
    .cpu_wr     (cpu_wr),
    .mem_wr     (mem_wr),
    .addr_sel   (addr_sel),
    .state      ()
  );

  beat_counter beat_counter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (beat_start),
    .step      (beat_step),
    .beat      (beat),
    .last_beat (last_beat)
  );

  cache_array #(
    .INDEX_BITS (INDEX_BITS)
  ) cache_array_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_addr   (paddr),
    .cpu_wdata  (pwdata),
    .beat       (beat),
    .fill_wr    (fill_wr),
    .cpu_wr     (cpu_wr),
    .addr_sel   (addr_sel),
    .fill_data  (mem_rdata),
    .hit        (hit),
    .dirty      (dirty),
    .cpu_rdata  (prdata),
    .line_rdata (line_rdata),
    .mem_addr   (mem_addr)
  );

  main_memory main_memory_inst (
    .clk   (clk),
    .wr    (mem_wr),
    .addr  (mem_addr),
    .wdata (line_rdata),
    .rdata (mem_rdata)
  );

endmodule

/* test/clock_gen.sv */
module clock_gen (
  output logic clk
);

  // 10 time unit period
  initial
  begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

/* test/cache_assert.sv */
module cache_fsm_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   psel,
  input logic                   pready,
  input logic                   mem_wr,
  input logic                   fill_wr,
  input cache_pkg::ctrl_state_t state
);

  logic psel_seen;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      psel_seen <= 1'b0;
    else if (psel)
      psel_seen <= 1'b1;
  end

  // Only an illegal encoding can lead here
  no_error_state: assert property (@(posedge clk) disable iff (!rst_n)
    state != cache_pkg::ST_ERROR)
    else $error("controller entered the error state");

  mem_wr_in_write_back: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wr |-> state == cache_pkg::ST_WRITE_BACK)
    else $error("memory write outside write-back");

  fill_wr_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
    fill_wr |-> state == cache_pkg::ST_FILL)
    else $error("line fill write outside fill");

  quiet_until_psel: assert property (@(posedge clk) disable iff (!rst_n)
    !psel_seen |-> !pready)
    else $error("pready high before any select");

endmodule

bind cache_fsm cache_fsm_assert cache_fsm_assert_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .pready  (pready),
  .mem_wr  (mem_wr),
  .fill_wr (fill_wr),
  .state   (state)
);

/* test/cache_tb.sv */
module cache_tb;

  localparam int INDEX_BITS     = 3;
  localparam int NUM_TRANS      = 400;
  // Up to 11 cycles per transfer and 3 idle cycles, with some margin
  localparam int TIMEOUT_CYCLES = NUM_TRANS * 15;
  localparam int ADDR_BITS      = $bits(cache_pkg::word_addr_t);
  localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - 2;
  localparam int LINES          = 1 << INDEX_BITS;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  cache_pkg::word_addr_t paddr;
  cache_pkg::data_t      pwdata;
  cache_pkg::data_t      prdata;
  logic                  pready;

  // Flat view of memory and a copy of the cache directory
  cache_pkg::data_t      model_mem [1 << ADDR_BITS];
  logic [TAG_BITS-1:0]   model_tag [LINES];
  logic [LINES-1:0]      model_valid;
  logic [LINES-1:0]      model_dirty;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  clock_gen clock_gen_inst (
    .clk (clk)
  );

  cache_top #(
    .INDEX_BITS (INDEX_BITS)
  ) cache_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready)
  );

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Run timed out after %0d cycles without finishing", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual)
    else
    begin
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Few tags over few indexes, so lines collide and get evicted often
  function automatic cache_pkg::word_addr_t pick_addr(input cache_pkg::word_addr_t prev);
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] idx;
    if ($urandom_range(3) == 0)
      return {prev[ADDR_BITS-1:2], 2'($urandom_range(3))};
    tag = TAG_BITS'($urandom_range(3) * 13);
    idx = INDEX_BITS'($urandom_range(3));
    return {tag, idx, 2'($urandom_range(3))};
  endfunction

  task automatic idle_cycles(input int count);
    repeat (count)
    begin
      psel    <= 1'b0;
      penable <= 1'b0;
      @(negedge clk);
      check_value("pready", 0, int'(pready));
      @(posedge clk);
    end
  endtask

  // Called on a rising edge, returns on the edge that completes the transfer
  task automatic apb_transfer(input logic write, input cache_pkg::word_addr_t addr,
                              input cache_pkg::data_t wdata);
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic                  predict_hit;
    int                    exp_wait;
    int                    waits;
    idx         = addr[2 +: INDEX_BITS];
    tag         = addr[ADDR_BITS-1 -: TAG_BITS];
    predict_hit = model_valid[idx] && (model_tag[idx] == tag);
    if (predict_hit)
      exp_wait = 0;
    else if (model_valid[idx] && model_dirty[idx])
      exp_wait = 9;
    else
      exp_wait = 5;

    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(negedge clk);
    check_value("pready", 0, int'(pready));
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready)
    begin
      @(negedge clk);
      waits++;
    end
    check_value("pready wait states", exp_wait, waits);
    if (!write)
      check_value("prdata", int'(model_mem[addr]), int'(prdata));
    @(posedge clk);

    // Allocate on any miss, then a write marks the line dirty
    if (!predict_hit)
    begin
      model_valid[idx] = 1'b1;
      model_dirty[idx] = 1'b0;
      model_tag[idx]   = tag;
    end
    if (write)
    begin
      model_dirty[idx] = 1'b1;
      model_mem[addr]  = wdata;
    end
  endtask

  initial
  begin
    cache_pkg::word_addr_t addr;
    cache_pkg::word_addr_t last_addr;
    logic                  write;
    void'($urandom(32'hefa9_be00));
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    for (int i = 0; i < (1 << ADDR_BITS); i++)
      model_mem[i] = '0;
    model_valid = '0;
    model_dirty = '0;
    last_addr   = '0;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Bus stays quiet for a while after reset
    idle_cycles(4);

    for (int n = 0; n < NUM_TRANS; n++)
    begin
      addr  = pick_addr(last_addr);
      write = 1'($urandom_range(1));
      apb_transfer(write, addr, 16'($urandom));
      last_addr = addr;
      idle_cycles(int'($urandom_range(3)));
    end
    idle_cycles(1);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* list.f */
hdl/cache_pkg.sv
hdl/beat_counter.sv
hdl/cache_array.sv
hdl/main_memory.sv
hdl/cache_fsm.sv
hdl/cache_top.sv
test/clock_gen.sv
test/cache_assert.sv
test/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
